/* source/calc_pkg.sv */
`default_nettype none

package calc_pkg;

    typedef logic [3:0]        digit_t;
    typedef logic signed [15:0] operand_t;
    typedef logic [1:0]        buf_addr_t;
    typedef logic [3:0]        key_idx_t;   // row * 4 + column

    // operator codes as seen on key_out
    typedef enum logic [2:0] {
        op_none = 3'b000,
        op_neg  = 3'b001,
        op_add  = 3'b010,
        op_sub  = 3'b011,
        op_mul  = 3'b100
    } op_t;

    typedef struct packed {
        logic      we;
        buf_addr_t addr;
        digit_t    data;
    } buf_write_t;

    typedef struct packed {
        logic      req;
        buf_addr_t addr;
    } buf_read_t;

    typedef struct packed {
        digit_t keypad_input;
        op_t    operator_input;
        logic   equal_input;
    } key_out_t;

    // keypad positions that do not carry a digit
    localparam key_idx_t key_add   = 4'h3;
    localparam key_idx_t key_sub   = 4'h7;
    localparam key_idx_t key_mul   = 4'hB;
    localparam key_idx_t key_eq    = 4'hC;
    localparam key_idx_t key_zero  = 4'hD;
    localparam key_idx_t key_blank = 4'hE;   // unlabelled key, never offered
    localparam key_idx_t key_neg   = 4'hF;

    // active-low segments, bit order g f e d c b a
    function automatic logic [6:0] seg7_encode(input digit_t d);
        logic [6:0] on;
        case (d)
            4'd0:    on = 7'h3F;
            4'd1:    on = 7'h06;
            4'd2:    on = 7'h5B;
            4'd3:    on = 7'h4F;
            4'd4:    on = 7'h66;
            4'd5:    on = 7'h6D;
            4'd6:    on = 7'h7D;
            4'd7:    on = 7'h07;
            4'd8:    on = 7'h7F;
            4'd9:    on = 7'h6F;
            default: on = 7'h40;   // dash for anything else
        endcase
        return ~on;
    endfunction

endpackage

`default_nettype wire

/* source/keypad_scanner.sv */
`default_nettype none

module keypad_scanner import calc_pkg::*; #(
    parameter int debounce_cycles = 500000,
    parameter int scan_cycles     = 50000
) (
    input  logic       clk,
    input  logic       nRST,
    input  logic [3:0] row_in,     // pulled up, low when pressed
    output logic [3:0] col_out,    // one column driven low
    output logic       read_input,
    input  logic       key_read,
    output key_out_t   key_out
);

    localparam int db_w   = $clog2(debounce_cycles + 1);
    localparam int scan_w = $clog2(scan_cycles + 1);
    localparam logic [db_w-1:0]   db_last   = db_w'(debounce_cycles - 1);
    localparam logic [scan_w-1:0] scan_last = scan_w'(scan_cycles - 1);

    typedef enum logic [2:0] {
        idle,
        scan_col,
        wait_stable,
        confirm,
        wait_release
    } scan_state_t;

    scan_state_t       state;
    logic [1:0]        col_index;
    logic [scan_w-1:0] scan_timer;
    logic [db_w-1:0]   debounce_cnt;
    logic              key_valid;
    logic              stable_done;
    key_idx_t          key_idx;

    // lowest pressed row wins if several are down
    function automatic key_idx_t encode_key(input logic [3:0] rows, input logic [1:0] col);
        key_idx_t idx;
        idx = key_blank;
        for (int r = 3; r >= 0; r--) begin
            if (!rows[r])
                idx = {2'(r), col};
        end
        return idx;
    endfunction

    function automatic key_out_t decode_key(input key_idx_t idx);
        key_out_t k;
        k = '0;
        case (idx)
            4'h0:     k.keypad_input = 4'd1;
            4'h1:     k.keypad_input = 4'd2;
            4'h2:     k.keypad_input = 4'd3;
            4'h4:     k.keypad_input = 4'd4;
            4'h5:     k.keypad_input = 4'd5;
            4'h6:     k.keypad_input = 4'd6;
            4'h8:     k.keypad_input = 4'd7;
            4'h9:     k.keypad_input = 4'd8;
            4'hA:     k.keypad_input = 4'd9;
            key_zero: k.keypad_input = 4'd0;
            key_add:  k.operator_input = op_add;
            key_sub:  k.operator_input = op_sub;
            key_mul:  k.operator_input = op_mul;
            key_neg:  k.operator_input = op_neg;
            key_eq:   k.equal_input = 1'b1;
            default:  k = '0;
        endcase
        return k;
    endfunction

    assign key_valid   = ~&row_in;
    assign col_out     = ~(4'b0001 << col_index);
    assign stable_done = (state == wait_stable) && key_valid && (debounce_cnt == db_last);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state        <= idle;
            col_index    <= '0;
            scan_timer   <= '0;
            debounce_cnt <= '0;
            read_input   <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    scan_timer <= '0;
                    state      <= scan_col;
                end
                scan_col: begin
                    if (key_valid) begin
                        debounce_cnt <= '0;
                        state        <= wait_stable;
                    end else if (scan_timer == scan_last) begin
                        scan_timer <= '0;
                        col_index  <= col_index + 2'd1;
                    end else begin
                        scan_timer <= scan_timer + 1'b1;
                    end
                end
                wait_stable: begin
                    if (!key_valid)
                        state <= scan_col;     // bounce, back to scanning
                    else if (stable_done)
                        state <= confirm;
                    else
                        debounce_cnt <= debounce_cnt + 1'b1;
                end
                confirm: begin
                    read_input <= (key_idx != key_blank);
                    state      <= wait_release;
                end
                wait_release: begin
                    if (read_input) begin
                        if (key_read)
                            read_input <= 1'b0;
                    end else if (!key_valid) begin
                        state <= idle;         // all rows high again
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // key payload, only sampled while its state qualifies it
    always_ff @(posedge clk) begin
        if (stable_done)
            key_idx <= encode_key(row_in, col_index);
        if (state == confirm)
            key_out <= decode_key(key_idx);
    end

endmodule

`default_nettype wire

/* source/calc_controller.sv */
`default_nettype none

module calc_controller import calc_pkg::*; (
    input  logic       clk,
    input  logic       nRST,
    input  logic       read_input,
    input  key_out_t   key_in,
    output logic       key_read,
    output buf_write_t buf_wr,
    output operand_t   result,
    output logic       result_valid,
    output logic       error_flag
);

    typedef enum logic [1:0] {
        ph_first,
        ph_second,
        ph_done
    } phase_t;

    phase_t    phase;
    operand_t  opa;
    operand_t  opb;
    logic      neg_a;
    logic      neg_b;
    op_t       op_latched;
    logic      fresh;          // next digit starts a new operand
    logic      take;
    logic      is_digit;
    operand_t  cur;
    operand_t  cur_next;
    digit_t    shadow [4];     // copy of what the buffer should hold
    logic      wr_busy;
    logic      wr_gap;
    buf_addr_t wr_cnt;

    function automatic operand_t apply_op(input op_t op, input operand_t a, input operand_t b);
        logic signed [31:0] prod;
        prod = a * b;
        case (op)
            op_add:  apply_op = a + b;
            op_sub:  apply_op = a - b;
            op_mul:  apply_op = prod[15:0];   // wraps to 16 bits
            default: apply_op = a;
        endcase
    endfunction

    assign take     = read_input && !key_read;
    assign is_digit = !key_in.equal_input && (key_in.operator_input == op_none);
    assign cur      = (phase == ph_second) ? opb : opa;
    assign cur_next = cur * 16'sd10 + $signed({12'd0, key_in.keypad_input});

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            key_read     <= 1'b0;
            result_valid <= 1'b0;
            error_flag   <= 1'b0;
            result       <= '0;
            buf_wr       <= '0;
            phase        <= ph_first;
            opa          <= '0;
            opb          <= '0;
            neg_a        <= 1'b0;
            neg_b        <= 1'b0;
            op_latched   <= op_none;
            fresh        <= 1'b1;
            wr_busy      <= 1'b0;
            wr_gap       <= 1'b0;
            wr_cnt       <= '0;
        end else begin
            key_read     <= take;
            result_valid <= 1'b0;
            buf_wr.we    <= 1'b0;

            // rest of the echo burst, one idle cycle between writes
            if (wr_busy) begin
                if (wr_gap) begin
                    wr_gap <= 1'b0;
                end else begin
                    buf_wr <= '{we: 1'b1, addr: wr_cnt, data: shadow[wr_cnt]};
                    wr_gap <= 1'b1;
                    wr_cnt <= wr_cnt + 2'd1;
                    if (wr_cnt == 2'd3)
                        wr_busy <= 1'b0;
                end
            end

            if (take && is_digit) begin
                if (phase == ph_second)
                    opb <= cur_next;
                else
                    opa <= cur_next;
                if (phase == ph_done)
                    phase <= ph_first;
                fresh      <= 1'b0;
                error_flag <= 1'b0;
                buf_wr     <= '{we: 1'b1, addr: 2'd0, data: key_in.keypad_input};
                wr_busy    <= 1'b1;
                wr_gap     <= 1'b1;
                wr_cnt     <= 2'd1;
            end else if (take && key_in.operator_input == op_neg) begin
                if (phase == ph_second)
                    neg_b <= !neg_b;
                else
                    neg_a <= !neg_a;
                if (phase == ph_done)
                    phase <= ph_first;
            end else if (take && !key_in.equal_input && phase != ph_done) begin
                op_latched <= key_in.operator_input;   // add, sub or mul
                if (phase == ph_first) begin
                    opb   <= '0;
                    neg_b <= 1'b0;
                    fresh <= 1'b1;
                    phase <= ph_second;
                end
            end

            // equals acts while key_read is up, key_in still stable
            if (key_read && key_in.equal_input) begin
                if (op_latched == op_none) begin
                    error_flag <= 1'b1;
                end else begin
                    result       <= apply_op(op_latched, neg_a ? -opa : opa,
                                             neg_b ? -opb : opb);
                    result_valid <= 1'b1;
                    opa          <= '0;
                    opb          <= '0;
                    neg_a        <= 1'b0;
                    neg_b        <= 1'b0;
                    op_latched   <= op_none;
                    fresh        <= 1'b1;
                    phase        <= ph_done;
                end
            end
        end
    end

    // newest digit at position 0, older ones move up
    always_ff @(posedge clk) begin
        if (take && is_digit) begin
            shadow[0] <= key_in.keypad_input;
            for (int i = 1; i < 4; i++)
                shadow[i] <= fresh ? digit_t'(0) : shadow[i-1];
        end
    end

endmodule

`default_nettype wire

/* source/digit_buffer.sv */
`default_nettype none

module digit_buffer import calc_pkg::*; (
    input  logic       clk,
    input  logic       nRST,
    input  buf_write_t wr,        // controller port, always wins
    input  buf_read_t  rd,        // display port
    output logic       rd_grant,
    output digit_t     rd_data
);

    digit_t mem [4];

    // fixed priority, the read waits out any write cycle
    assign rd_grant = rd.req && !wr.we;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < 4; i++)
                mem[i] <= '0;
        end else if (wr.we) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // data follows the grant by one cycle
    always_ff @(posedge clk) begin
        if (rd_grant)
            rd_data <= mem[rd.addr];
    end

endmodule

`default_nettype wire

/* source/display_scan.sv */
`default_nettype none

module display_scan import calc_pkg::*; #(
    parameter int refresh_cycles = 50000
) (
    input  logic       clk,
    input  logic       nRST,
    output buf_read_t  rd,
    input  logic       rd_grant,
    input  digit_t     rd_data,
    output logic [3:0] anode,     // active low
    output logic [6:0] seg        // active low
);

    localparam int rf_w = $clog2(refresh_cycles + 1);
    localparam logic [rf_w-1:0] rf_last = rf_w'(refresh_cycles - 1);

    logic [rf_w-1:0] timer;
    buf_addr_t       next_pos;
    logic            data_due;    // rd_data valid this cycle

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            timer    <= '0;
            next_pos <= '0;
            rd       <= '0;
            data_due <= 1'b0;
            anode    <= 4'b1111;
            seg      <= 7'h7F;
        end else begin
            data_due <= rd_grant;
            if (rd.req) begin
                if (rd_grant)
                    rd.req <= 1'b0;                 // hold until granted
            end else if (!data_due) begin
                if (timer == rf_last) begin
                    timer    <= '0;
                    rd       <= '{req: 1'b1, addr: next_pos};
                    next_pos <= next_pos + 2'd1;
                end else begin
                    timer <= timer + 1'b1;
                end
            end
            if (data_due) begin
                anode <= ~(4'b0001 << rd.addr);     // addr still held from request
                seg   <= seg7_encode(rd_data);
            end
        end
    end

endmodule

`default_nettype wire

/* source/calc_top.sv */
`default_nettype none

module calc_top import calc_pkg::*; #(
    parameter int debounce_cycles = 500000,
    parameter int scan_cycles     = 50000,
    parameter int refresh_cycles  = 50000
) (
    input  logic       clk,
    input  logic       nRST,
    input  logic [3:0] row_in,
    output logic [3:0] col_out,
    output logic [3:0] anode,
    output logic [6:0] seg,
    output operand_t   result,
    output logic       result_valid,
    output logic       error_flag
);

    logic       read_input;
    logic       key_read;
    key_out_t   key;
    buf_write_t buf_wr;
    buf_read_t  buf_rd;
    logic       rd_grant;
    digit_t     rd_data;

    keypad_scanner #(
        .debounce_cycles(debounce_cycles),
        .scan_cycles    (scan_cycles)
    ) scanner0 (
        .clk       (clk),
        .nRST      (nRST),
        .row_in    (row_in),
        .col_out   (col_out),
        .read_input(read_input),
        .key_read  (key_read),
        .key_out   (key)
    );

    calc_controller ctrl0 (
        .clk         (clk),
        .nRST        (nRST),
        .read_input  (read_input),
        .key_in      (key),
        .key_read    (key_read),
        .buf_wr      (buf_wr),
        .result      (result),
        .result_valid(result_valid),
        .error_flag  (error_flag)
    );

    digit_buffer buf0 (
        .clk     (clk),
        .nRST    (nRST),
        .wr      (buf_wr),
        .rd      (buf_rd),
        .rd_grant(rd_grant),
        .rd_data (rd_data)
    );

    display_scan #(
        .refresh_cycles(refresh_cycles)
    ) disp0 (
        .clk     (clk),
        .nRST    (nRST),
        .rd      (buf_rd),
        .rd_grant(rd_grant),
        .rd_data (rd_data),
        .anode   (anode),
        .seg     (seg)
    );

endmodule

`default_nettype wire

/* bench/calc_properties.sv */
`default_nettype none

module calc_properties (
    input logic clk,
    input logic nRST,
    input logic read_input,
    input logic key_read,
    input logic result_valid,
    input logic wr_we,
    input logic rd_req,
    input logic rd_grant
);
    timeunit 1ns;
    timeprecision 1ps;

    // the scanner withdraws its offer right after the acknowledge
    key_read_pulse: assert property (@(posedge clk) disable iff (!nRST)
        key_read |=> !key_read && !read_input)
        else $error("key_read held or key offer not withdrawn after it");

    result_valid_pulse: assert property (@(posedge clk) disable iff (!nRST)
        result_valid |=> !result_valid)
        else $error("result_valid longer than one cycle");

    // a colliding read loses the write cycle and wins the next one
    write_beats_read: assert property (@(posedge clk) disable iff (!nRST)
        rd_req && wr_we |-> !rd_grant ##1 rd_grant)
        else $error("read not held off for exactly the write cycle");

    read_granted_soon: assert property (@(posedge clk) disable iff (!nRST)
        rd_req |-> ##[0:2] rd_grant)
        else $error("read request not granted within 2 cycles");

endmodule

// buffer ports tied off on the controller side and vice versa
bind calc_controller calc_properties ctrl_props (
    .clk         (clk),
    .nRST        (nRST),
    .read_input  (read_input),
    .key_read    (key_read),
    .result_valid(result_valid),
    .wr_we       (1'b0),
    .rd_req      (1'b0),
    .rd_grant    (1'b0)
);

bind digit_buffer calc_properties buf_props (
    .clk         (clk),
    .nRST        (nRST),
    .read_input  (1'b0),
    .key_read    (1'b0),
    .result_valid(1'b0),
    .wr_we       (wr.we),
    .rd_req      (rd.req),
    .rd_grant    (rd_grant)
);

`default_nettype wire

/* bench/calc_tb.sv */
`default_nettype none

module calc_tb import calc_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int press_timeout  = 200;
    localparam int result_timeout = 2000;
    localparam int anode_timeout  = 500;
    localparam int long_hold      = 300;
    localparam int short_hold     = 4;     // well under debounce_cycles

    logic       clk;
    logic       nRST;
    logic [3:0] row_in;
    logic [3:0] col_out;
    logic [3:0] anode;
    logic [6:0] seg;
    operand_t   result;
    logic       result_valid;
    logic       error_flag;

    // keypad model state
    logic       key_down;
    logic [1:0] key_row;
    logic [1:0] key_col;

    integer seed;
    int     errors;
    int     checks;
    int     ntests;
    logic   aborted;
    string  test_name;

    calc_top #(
        .debounce_cycles(8),
        .scan_cycles    (4),
        .refresh_cycles (6)
    ) dut0 (
        .clk         (clk),
        .nRST        (nRST),
        .row_in      (row_in),
        .col_out     (col_out),
        .anode       (anode),
        .seg         (seg),
        .result      (result),
        .result_valid(result_valid),
        .error_flag  (error_flag)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // pressed row reads low only while its column is driven
    always @(negedge clk) begin
        if (key_down && !col_out[key_col])
            row_in <= ~(4'b0001 << key_row);
        else
            row_in <= 4'hF;
    end

    // keypad layout row by row with the dot as the unlabelled key
    function automatic logic key_position(input byte sym, output logic [1:0] r,
                                          output logic [1:0] c);
        string layout = "123+456-789*=0.n";
        r = '0;
        c = '0;
        for (int i = 0; i < 16; i++) begin
            if (layout[i] == sym) begin
                r = 2'(i / 4);
                c = 2'(i % 4);
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // active-low gfedcba pattern back to a digit or -1
    function automatic int seg_to_digit(input logic [6:0] s);
        case (~s)
            7'h3F:   return 0;
            7'h06:   return 1;
            7'h5B:   return 2;
            7'h4F:   return 3;
            7'h66:   return 4;
            7'h6D:   return 5;
            7'h7D:   return 6;
            7'h07:   return 7;
            7'h7F:   return 8;
            7'h6F:   return 9;
            default: return -1;
        endcase
    endfunction

    task automatic check_value(input string what, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            $display("FAIL %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic give_up(input string what);
        $display("timeout in test %s while waiting for %s", test_name, what);
        errors++;
        aborted = 1'b1;
    endtask

    // hold 0 means release once the controller takes the key
    task automatic press_key(input byte sym, input int hold);
        logic [1:0] r;
        logic [1:0] c;
        int         gap;
        int         n;
        if (!key_position(sym, r, c)) begin
            $display("test %s uses unknown key symbol %c", test_name, sym);
            errors++;
            return;
        end
        gap = $unsigned($random(seed)) % 16;
        repeat (gap) @(negedge clk);
        @(negedge clk);
        key_row  <= r;
        key_col  <= c;
        key_down <= 1'b1;
        n = 0;
        if (hold == short_hold) begin
            repeat (short_hold) @(negedge clk);
        end else begin
            while (!dut0.key_read && n < press_timeout) begin
                @(negedge clk);
                n++;
            end
            if (!dut0.key_read)
                give_up("a key to be taken");
            while (n < hold) begin        // long press keeps holding
                @(negedge clk);
                n++;
            end
        end
        key_down <= 1'b0;
    endtask

    task automatic wait_anode(input int pos);
        int n;
        n = 0;
        while (anode != ~(4'b0001 << pos) && n < anode_timeout) begin
            @(negedge clk);
            n++;
        end
        if (anode != ~(4'b0001 << pos))
            give_up($sformatf("anode %0d", pos));
    endtask

    task automatic check_display(input string keys);
        int want [4];
        int k;
        k = 0;
        for (int i = 0; i < 4; i++)
            want[i] = 0;
        // newest digit sits at position 0
        for (int i = keys.len() - 1; i >= 0 && k < 4; i--) begin
            if (keys[i] >= "0" && keys[i] <= "9" && !(i > 0 && keys[i-1] == "~")) begin
                want[k] = keys[i] - "0";
                k++;
            end
        end
        wait_anode(2);                   // skip ahead until every echo write has landed
        if (!aborted)
            wait_anode(3);
        for (int p = 0; p < 4 && !aborted; p++) begin
            wait_anode(p);
            if (!aborted)
                check_value($sformatf("digit %0d", p), want[p], seg_to_digit(seg));
        end
    endtask

    task automatic run_test(input string keys, input string expect_str);
        int hold;
        int want;
        int n;
        hold = 0;
        for (int i = 0; i < keys.len() && !aborted; i++) begin
            if (keys[i] == "~") begin
                hold = short_hold;
            end else if (keys[i] == "_") begin
                hold = long_hold;
            end else begin
                press_key(keys[i], hold);
                hold = 0;
            end
        end
        if (aborted)
            return;
        n = 0;
        if (expect_str == "echo") begin
            check_display(keys);
        end else if (expect_str == "err") begin
            while (!error_flag && n < result_timeout) begin
                @(negedge clk);
                n++;
            end
            if (!error_flag)
                give_up("error_flag");
        end else begin
            if ($sscanf(expect_str, "%d", want) != 1) begin
                $display("bad expected value %s in test %s", expect_str, test_name);
                errors++;
                return;
            end
            while (!result_valid && n < result_timeout) begin
                @(negedge clk);
                n++;
            end
            if (!result_valid) begin
                give_up("result_valid");
            end else begin
                check_value("result", int'(operand_t'(want)), int'(result));
                check_value("error_flag", 0, int'(error_flag));
            end
        end
    endtask

    initial begin
        int    fd;
        string line;
        string keys;
        string expect_str;
        seed     = 30;
        errors   = 0;
        checks   = 0;
        ntests   = 0;
        aborted  = 1'b0;
        nRST     = 1'b0;
        row_in   = 4'hF;
        key_down = 1'b0;
        key_row  = '0;
        key_col  = '0;
        repeat (8) @(negedge clk);
        nRST = 1'b1;
        @(negedge clk);
        test_name = "reset";
        check_value("col_out", 4'b1110, col_out);
        check_value("anode", 4'b1111, anode);
        check_value("result_valid", 0, result_valid);
        check_value("error_flag", 0, error_flag);

        fd = $fopen("bench/calc_input.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/calc_input.txt");
            errors++;
            aborted = 1'b1;
        end
        while (!aborted && !$feof(fd)) begin
            if ($fgets(line, fd) == 0)
                break;
            if (line.len() < 3 || line[0] == "#")
                continue;                // blank or comment
            if ($sscanf(line, "%s %s %s", test_name, keys, expect_str) != 3) begin
                $display("malformed line in input file: %s", line);
                errors++;
                continue;
            end
            ntests++;
            run_test(keys, expect_str);
        end
        if (fd != 0)
            $fclose(fd);
        if (ntests == 0) begin
            $display("no tests were read from the input file");
            errors++;
        end

        $display("tests run %0d, checks %0d, errors %0d", ntests, checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/calc_input.txt */
# columns are test name, key sequence, expected result (decimal, err or echo)
# keys 0-9 + - * = and n for negate, ~ marks a short press, _ a 300-cycle hold
add_multi   123+456=     579
sub_neg     50-75=       -25
mul_big     300*300=     24464
mul_wrap    250*250=     -3036
neg_first   12n+5=       -7
neg_second  20-n7=       27
neg_both    n6*n7=       42
short_press 1~23+4=      17
long_hold   _7*_8=       56
eq_no_op    =            err
err_clear   9-4=         5
entry_wrap  40000+1=     -25535
echo_digits 123          echo

/* build.f */
source/calc_pkg.sv
source/keypad_scanner.sv
source/calc_controller.sv
source/digit_buffer.sv
source/display_scan.sv
source/calc_top.sv
bench/calc_properties.sv
bench/calc_tb.sv
